/* cmdin_config.svh */
`ifndef CMDIN_CONFIG_SVH
`define CMDIN_CONFIG_SVH

// Stream word width
`define CMDIN_DATA_W 64

// Accelerators behind the command-in path
`define CMDIN_NUM_ACCS 16
`define CMDIN_ACC_W 4

// Arguments per command, the index field covers 0 to 14
`define CMDIN_MAX_ARGS 15
`define CMDIN_IDX_W 4

`endif

/* cmdFormatPkg.sv */
`include "cmdin_config.svh"

package cmdFormatPkg;

    typedef logic [`CMDIN_DATA_W-1:0] cmdData_t;
    typedef logic [`CMDIN_ACC_W-1:0] accId_t;
    typedef logic [`CMDIN_IDX_W-1:0] argIdx_t;

    typedef logic [7:0] cmdCode_t;
    localparam cmdCode_t EXEC_TASK_CODE = 8'h03;
    localparam cmdCode_t EXEC_PERI_TASK_CODE = 8'h05;
    localparam cmdCode_t SETUP_HW_INST_CODE = 8'h08;

    typedef logic [7:0] argFlags_t;
    localparam int IN_COPY_BIT = 4;
    localparam int OUT_COPY_BIT = 5;

    localparam logic [7:0] EXEC_DEST_ID = 8'h11; // Required on every execute header

    // Header word fields
    localparam int CMD_TYPE_L = 0;
    localparam int CMD_TYPE_H = 7;
    localparam int NUM_ARGS_L = 8;
    localparam int NUM_ARGS_H = 15;
    localparam int DESTID_L = 24;
    localparam int DESTID_H = 31;

    // Argument flag word fields
    localparam int ARG_FLAG_L = 0;
    localparam int ARG_FLAG_H = 7;
    localparam int ARG_IDX_L = 32;
    localparam int ARG_IDX_H = 63;

endpackage

/* cmdFlowPkg.sv */
package cmdFlowPkg;

    typedef enum logic [2:0] {
        KIND_HEADER,
        KIND_TID,
        KIND_PTID,
        KIND_PERIOD,
        KIND_ARGFLAG,
        KIND_ARG
    } wordKind_t;

    typedef enum logic [2:0] {
        ST_HEADER,
        ST_TID,
        ST_PTID,
        ST_PERIOD,
        ST_ARGFLAG,
        ST_ARG,
        ST_DISCARD // Drop words until last
    } parseState_t;

    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_BAD_TYPE,
        ERR_BAD_DEST,
        ERR_TOO_MANY_ARGS,
        ERR_MISSING_LAST,
        ERR_EARLY_LAST,
        ERR_ARG_INDEX
    } errCode_t;

endpackage

/* cmdWordIf.sv */
interface cmdWordIf;
    import cmdFormatPkg::*;
    import cmdFlowPkg::*;

    logic      valid;  // Single-cycle strobe, no back-pressure
    cmdData_t  data;
    logic      last;
    accId_t    dest;
    wordKind_t kind;
    argIdx_t   argIdx; // Argument index for flag and value words

    modport source (
        output valid, output data, output last,
        output dest, output kind, output argIdx
    );

    modport sink (
        input valid, input data, input last,
        input dest, input kind, input argIdx
    );

endinterface

/* argHistIf.sv */
interface argHistIf;
    import cmdFormatPkg::*;

    logic     req;
    accId_t   dest;
    argIdx_t  argIdx;
    cmdData_t value;
    logic     hit; // Same-cycle compare result

    modport requester (
        output req, output dest, output argIdx, output value,
        input hit
    );

    modport store (
        input req, input dest, input argIdx, input value,
        output hit
    );

endinterface

/* cmdParser.sv */
`include "cmdin_config.svh"

module cmdParser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  cmdFormatPkg::cmdData_t inData,
    input  logic                   inLast,
    input  cmdFormatPkg::accId_t   inDest,
    cmdWordIf.source               words,
    output logic                   errValid,
    output cmdFlowPkg::errCode_t   errCode
);
    import cmdFormatPkg::*;
    import cmdFlowPkg::*;

    parseState_t state;
    parseState_t stateNext;
    cmdCode_t    code;     // Type of the command being parsed
    argIdx_t     argCount; // Arguments announced in the header
    argIdx_t     argCnt;   // Running argument index
    cmdCode_t    hdrCode;
    logic [7:0]  hdrArgs;
    logic        isFinal;
    logic        fwd;
    wordKind_t   kind;
    errCode_t    err;

    assign hdrCode = inData[CMD_TYPE_H:CMD_TYPE_L];
    assign hdrArgs = inData[NUM_ARGS_H:NUM_ARGS_L];

    always_comb begin
        stateNext = state;
        fwd       = 1'b0;
        kind      = KIND_HEADER;
        err       = ERR_NONE;
        isFinal   = 1'b0;
        case (state)
            ST_HEADER: begin
                if (hdrCode != EXEC_TASK_CODE && hdrCode != EXEC_PERI_TASK_CODE &&
                    hdrCode != SETUP_HW_INST_CODE) begin
                    err = ERR_BAD_TYPE;
                end else if (hdrCode != SETUP_HW_INST_CODE &&
                             inData[DESTID_H:DESTID_L] != EXEC_DEST_ID) begin
                    err = ERR_BAD_DEST;
                end else if (hdrCode != SETUP_HW_INST_CODE && hdrArgs > `CMDIN_MAX_ARGS) begin
                    err = ERR_TOO_MANY_ARGS;
                end
                stateNext = ST_TID;
            end
            ST_TID: begin
                kind      = KIND_TID;
                isFinal   = (code == SETUP_HW_INST_CODE); // Setup ends at its task id
                stateNext = isFinal ? ST_HEADER : ST_PTID;
            end
            ST_PTID: begin
                kind    = KIND_PTID;
                isFinal = (code == EXEC_TASK_CODE) && (argCount == '0);
                if (code == EXEC_PERI_TASK_CODE) begin
                    stateNext = ST_PERIOD;
                end else if (argCount != '0) begin
                    stateNext = ST_ARGFLAG;
                end else begin
                    stateNext = ST_HEADER;
                end
            end
            ST_PERIOD: begin
                kind      = KIND_PERIOD;
                isFinal   = (argCount == '0);
                stateNext = isFinal ? ST_HEADER : ST_ARGFLAG;
            end
            ST_ARGFLAG: begin
                kind = KIND_ARGFLAG;
                if (inData[ARG_IDX_H:ARG_IDX_L] != 32'(argCnt)) begin
                    err = ERR_ARG_INDEX;
                end
                stateNext = ST_ARG;
            end
            ST_ARG: begin
                kind      = KIND_ARG;
                isFinal   = (argCnt == argIdx_t'(argCount - 4'd1));
                stateNext = isFinal ? ST_HEADER : ST_ARGFLAG;
            end
            default: begin
            end
        endcase

        // Last marker is checked only on an otherwise well formed word
        if (state != ST_DISCARD && err == ERR_NONE) begin
            if (isFinal && !inLast) begin
                err = ERR_MISSING_LAST;
            end else if (!isFinal && inLast) begin
                err = ERR_EARLY_LAST;
            end
        end

        if (state == ST_DISCARD || err != ERR_NONE) begin
            stateNext = inLast ? ST_HEADER : ST_DISCARD;
        end else begin
            fwd = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_HEADER;
            words.valid <= 1'b0;
            errValid    <= 1'b0;
        end else begin
            words.valid <= inValid && fwd;
            errValid    <= inValid && (err != ERR_NONE);
            if (inValid) begin
                state <= stateNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        errCode      <= err;
        words.data   <= inData;
        words.last   <= inLast;
        words.dest   <= inDest;
        words.kind   <= kind;
        words.argIdx <= argCnt;
        if (inValid && fwd) begin
            if (state == ST_HEADER) begin
                code     <= hdrCode;
                argCount <= argIdx_t'(hdrArgs);
                argCnt   <= '0;
            end
            if (state == ST_ARG) begin
                argCnt <= argCnt + 4'd1;
            end
        end
    end

    aArgIdxRange: assert property (@(posedge clk) disable iff (rst)
        words.valid && (words.kind == KIND_ARGFLAG || words.kind == KIND_ARG)
        |-> words.argIdx <= `CMDIN_MAX_ARGS - 1);

endmodule

/* argHistory.sv */
`include "cmdin_config.svh"

module argHistory (
    input  logic    clk,
    input  logic    rst,
    argHistIf.store hist
);
    import cmdFormatPkg::*;

    cmdData_t                   argValue [`CMDIN_NUM_ACCS][`CMDIN_MAX_ARGS];
    logic [`CMDIN_MAX_ARGS-1:0] argSeen [`CMDIN_NUM_ACCS]; // Entry holds a real value

    // Compare against the value stored by the previous command
    assign hist.hit = hist.req && argSeen[hist.dest][hist.argIdx] &&
                      (argValue[hist.dest][hist.argIdx] == hist.value);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < `CMDIN_NUM_ACCS; a++) begin
                argSeen[a] <= '0;
            end
        end else if (hist.req) begin
            argSeen[hist.dest][hist.argIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hist.req) begin
            argValue[hist.dest][hist.argIdx] <= hist.value; // Overwrite after compare
        end
    end

    aIdxInRange: assert property (@(posedge clk) disable iff (rst)
        hist.req |-> hist.argIdx < `CMDIN_MAX_ARGS);

endmodule

/* copyOptimizer.sv */
module copyOptimizer (
    input  logic                   clk,
    input  logic                   rst,
    cmdWordIf.sink                 words,
    argHistIf.requester            hist,
    output logic                   outValid,
    output cmdFormatPkg::cmdData_t outData,
    output logic                   outLast,
    output cmdFormatPkg::accId_t   outDest
);
    import cmdFormatPkg::*;
    import cmdFlowPkg::*;

    logic      heldValid;
    cmdData_t  heldData;
    logic      heldLast;
    accId_t    heldDest;
    wordKind_t heldKind;
    logic      emit;
    argFlags_t emitFlags;
    cmdData_t  emitData;

    // Value word arriving behind its own flag word
    assign hist.req    = words.valid && (words.kind == KIND_ARG) &&
                         heldValid && (heldKind == KIND_ARGFLAG);
    assign hist.dest   = words.dest;
    assign hist.argIdx = words.argIdx;
    assign hist.value  = words.data;

    assign emit = heldValid && (words.valid || heldLast); // Last word flushes itself

    always_comb begin
        emitFlags = heldData[ARG_FLAG_H:ARG_FLAG_L];
        emitData  = heldData;
        if (hist.hit) begin
            emitFlags[IN_COPY_BIT]            = 1'b0; // Same argument already on the accelerator
            emitData[ARG_FLAG_H:ARG_FLAG_L] = emitFlags;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
            outValid  <= 1'b0;
        end else begin
            outValid <= emit;
            if (words.valid) begin
                heldValid <= 1'b1;
            end else if (emit) begin
                heldValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (words.valid) begin
            heldData <= words.data;
            heldLast <= words.last;
            heldDest <= words.dest;
            heldKind <= words.kind;
        end
        if (emit) begin
            outData <= emitData;
            outLast <= heldLast;
            outDest <= heldDest;
        end
    end

    aArgAfterFlag: assert property (@(posedge clk) disable iff (rst)
        words.valid && words.kind == KIND_ARG |-> heldValid && heldKind == KIND_ARGFLAG);

endmodule

/* cmdInPath.sv */
module cmdInPath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  cmdFormatPkg::cmdData_t inData,
    input  logic                   inLast,
    input  cmdFormatPkg::accId_t   inDest,
    output logic                   outValid,
    output cmdFormatPkg::cmdData_t outData,
    output logic                   outLast,
    output cmdFormatPkg::accId_t   outDest,
    output logic                   errValid,
    output cmdFlowPkg::errCode_t   errCode
);

    cmdWordIf wordBus ();
    argHistIf histBus ();

    cmdParser i_cmdParser (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inData   (inData),
        .inLast   (inLast),
        .inDest   (inDest),
        .words    (wordBus.source),
        .errValid (errValid),
        .errCode  (errCode)
    );

    copyOptimizer i_copyOptimizer (
        .clk      (clk),
        .rst      (rst),
        .words    (wordBus.sink),
        .hist     (histBus.requester),
        .outValid (outValid),
        .outData  (outData),
        .outLast  (outLast),
        .outDest  (outDest)
    );

    argHistory i_argHistory (
        .clk  (clk),
        .rst  (rst),
        .hist (histBus.store)
    );

endmodule

/* tbCmdInPath.sv */
`include "cmdin_config.svh"

module tbCmdInPath;
    timeunit 1ns;
    timeprecision 1ps;
    import cmdFormatPkg::*;
    import cmdFlowPkg::*;

    localparam int MAX_ROWS  = 12;
    localparam int MAX_WORDS = 12;

    localparam cmdData_t ARG_A  = 64'h1111_2222_3333_4444;
    localparam cmdData_t ARG_B  = 64'h5555_6666_7777_8888;
    localparam cmdData_t ARG_B2 = 64'h5555_6666_7777_8889;
    localparam cmdData_t ARG_C  = 64'h0123_4567_89ab_cdef;
    localparam cmdData_t ARG_D  = 64'h0000_0000_0000_1000;

    typedef struct packed {
        cmdData_t data;
        accId_t   dest;
        logic     last;
    } outWord_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     inValid = 1'b0;
    cmdData_t inData = '0;
    logic     inLast = 1'b0;
    accId_t   inDest = '0;
    logic     outValid;
    cmdData_t outData;
    logic     outLast;
    accId_t   outDest;
    logic     errValid;
    errCode_t errCode;

    string    rowName [MAX_ROWS];
    accId_t   rowDest [MAX_ROWS];
    errCode_t rowErr [MAX_ROWS];
    int       rowKeep [MAX_ROWS]; // Leading words that reach the output
    bit       rowReset [MAX_ROWS];
    int       rowLen [MAX_ROWS];
    cmdData_t rowData [MAX_ROWS][MAX_WORDS];
    bit       rowLast [MAX_ROWS][MAX_WORDS];
    int       numRows = 0;

    cmdData_t    histVal [`CMDIN_NUM_ACCS][`CMDIN_MAX_ARGS]; // Model of the argument history
    bit          histOk [`CMDIN_NUM_ACCS][`CMDIN_MAX_ARGS];
    outWord_t    expQ [$];
    outWord_t    actQ [$];
    errCode_t    errQ [$];
    bit          heldPending = 1'b0; // Tail of a cut command still sits in the optimizer
    bit          timedOut = 1'b0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] rngState = 32'h13ee;

    always #50 clk = ~clk;

    cmdInPath i_cmdInPath (.*);

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (outValid) begin
            actQ.push_back(outWord_t'({outData, outDest, outLast}));
        end
        if (errValid) begin
            errQ.push_back(errCode);
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic cmdData_t hdrWord(cmdCode_t code, int nArgs);
        cmdData_t w;
        w = '0;
        w[CMD_TYPE_H:CMD_TYPE_L] = code;
        w[NUM_ARGS_H:NUM_ARGS_L] = 8'(nArgs);
        w[DESTID_H:DESTID_L]     = EXEC_DEST_ID;
        return w;
    endfunction

    function automatic cmdData_t flagWord(int idx, argFlags_t flags);
        cmdData_t w;
        w = '0;
        w[ARG_FLAG_H:ARG_FLAG_L] = flags;
        w[ARG_IDX_H:ARG_IDX_L]   = 32'(idx);
        return w;
    endfunction

    task automatic addRow(string name, accId_t dest, errCode_t err, int keep, bit rstFirst);
        rowName[numRows]  = name;
        rowDest[numRows]  = dest;
        rowErr[numRows]   = err;
        rowKeep[numRows]  = keep;
        rowReset[numRows] = rstFirst;
        rowLen[numRows]   = 0;
        numRows++;
    endtask

    task automatic addWord(cmdData_t data, bit last);
        int r;
        r = numRows - 1;
        rowData[r][rowLen[r]] = data;
        rowLast[r][rowLen[r]] = last;
        rowLen[r]++;
    endtask

    task automatic addExec(cmdCode_t code, int nArgs, cmdData_t tid);
        addWord(hdrWord(code, nArgs), 1'b0);
        addWord(tid, 1'b0);
        addWord(tid - 64'd1, 1'b0); // Parent task id
    endtask

    task automatic addArg(int idx, argFlags_t flags, cmdData_t value, bit last);
        addWord(flagWord(idx, flags), 1'b0);
        addWord(value, last);
    endtask

    task automatic checkWord(string name, cmdData_t got, cmdData_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkDest(string name, accId_t got, accId_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkLast(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkErr(string name, errCode_t got, errCode_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    // Forwarded words of a row, with the in-copy flag cleared on a repeated argument
    task automatic buildExpected(int r);
        cmdData_t exp [MAX_WORDS];
        int       firstArg;
        int       idx;
        accId_t   d;
        d = rowDest[r];
        firstArg = (rowData[r][0][CMD_TYPE_H:CMD_TYPE_L] == EXEC_PERI_TASK_CODE) ? 4 : 3;
        for (int i = 0; i < rowKeep[r]; i++) begin
            exp[i] = rowData[r][i];
        end
        for (int i = firstArg; i + 1 < rowKeep[r]; i += 2) begin
            idx = (i - firstArg) / 2;
            if (histOk[d][idx] && histVal[d][idx] == exp[i + 1]) begin
                exp[i][IN_COPY_BIT] = 1'b0;
            end
            histOk[d][idx]  = 1'b1;
            histVal[d][idx] = exp[i + 1];
        end
        for (int i = 0; i < rowKeep[r]; i++) begin
            expQ.push_back(outWord_t'({exp[i], d, rowLast[r][i]}));
        end
        if (rowKeep[r] > 0) begin
            heldPending = (rowKeep[r] < rowLen[r]);
        end
    endtask

    task automatic driveRow(int r);
        for (int i = 0; i < rowLen[r]; i++) begin
            rngState = xorshift32(rngState);
            repeat (rngState[1:0]) begin
                @(negedge clk);
                inValid = 1'b0;
            end
            @(negedge clk);
            inValid = 1'b1;
            inData  = rowData[r][i];
            inLast  = rowLast[r][i];
            inDest  = rowDest[r];
        end
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitForEntry(bit forErr);
        int cyc;
        cyc = 0;
        while ((forErr ? errQ.size() : actQ.size()) == 0 && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if ((forErr ? errQ.size() : actQ.size()) == 0) begin
            $display("timeout at %0t: no %s within 20 cycles", $time,
                     forErr ? "error strobe" : "output word");
            timedOut = 1'b1;
            errors++;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst     = 1'b1;
        inValid = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (histOk[a, i]) begin
            histOk[a][i] = 1'b0;
        end
        heldPending = 1'b0;
    endtask

    initial begin
        int       errBefore;
        int       due;
        outWord_t got;
        outWord_t exp;

        addRow("setup command", 4'd1, ERR_NONE, 2, 1'b0);
        addWord(hdrWord(SETUP_HW_INST_CODE, 0), 1'b0);
        addWord(64'h0000_0000_0000_0077, 1'b1);
        addRow("first execute to acc 2", 4'd2, ERR_NONE, 9, 1'b0);
        addExec(EXEC_TASK_CODE, 3, 64'h100);
        addArg(0, 8'h10, ARG_A, 1'b0);
        addArg(1, 8'h30, ARG_B, 1'b0);
        addArg(2, 8'h11, ARG_C, 1'b1);
        addRow("repeated args to acc 2", 4'd2, ERR_NONE, 9, 1'b0);
        addExec(EXEC_TASK_CODE, 3, 64'h101);
        addArg(0, 8'h10, ARG_A, 1'b0);
        addArg(1, 8'h30, ARG_B2, 1'b0);
        addArg(2, 8'h11, ARG_C, 1'b1);
        addRow("same args to acc 5", 4'd5, ERR_NONE, 9, 1'b0);
        addExec(EXEC_TASK_CODE, 3, 64'h102);
        addArg(0, 8'h10, ARG_A, 1'b0);
        addArg(1, 8'h30, ARG_B2, 1'b0);
        addArg(2, 8'h11, ARG_C, 1'b1);
        addRow("periodic to acc 2", 4'd2, ERR_NONE, 8, 1'b0);
        addExec(EXEC_PERI_TASK_CODE, 2, 64'h103);
        addWord(64'd1000, 1'b0); // Period
        addArg(0, 8'h10, ARG_A, 1'b0);
        addArg(1, 8'h10, ARG_D, 1'b1);
        addRow("unknown type", 4'd3, ERR_BAD_TYPE, 0, 1'b0);
        addExec(8'h42, 1, 64'h104);
        addArg(0, 8'h10, ARG_A, 1'b1);
        addRow("missing last", 4'd3, ERR_MISSING_LAST, 4, 1'b0);
        addExec(EXEC_TASK_CODE, 1, 64'h105);
        addArg(0, 8'h10, ARG_B, 1'b0);
        addWord(64'h0000_0000_0000_dead, 1'b1); // Closes the broken command
        addRow("wrong argument index", 4'd3, ERR_ARG_INDEX, 5, 1'b0);
        addExec(EXEC_TASK_CODE, 2, 64'h106);
        addArg(0, 8'h10, ARG_C, 1'b0);
        addArg(3, 8'h10, ARG_D, 1'b1);
        addRow("valid after errors", 4'd3, ERR_NONE, 5, 1'b0);
        addExec(EXEC_TASK_CODE, 1, 64'h107);
        addArg(0, 8'h10, ARG_C, 1'b1);
        addRow("repeat after reset", 4'd2, ERR_NONE, 9, 1'b1);
        addExec(EXEC_TASK_CODE, 3, 64'h101);
        addArg(0, 8'h10, ARG_A, 1'b0);
        addArg(1, 8'h30, ARG_B2, 1'b0);
        addArg(2, 8'h11, ARG_C, 1'b1);

        applyReset();
        for (int r = 0; r < numRows && !timedOut; r++) begin
            if (rowReset[r]) begin
                applyReset();
            end
            errBefore = errors;
            driveRow(r);
            buildExpected(r);
            due = expQ.size() - int'(heldPending);
            for (int k = 0; k < due && !timedOut; k++) begin
                waitForEntry(1'b0);
                if (!timedOut) begin
                    got = actQ.pop_front();
                    exp = expQ.pop_front();
                    checkWord("outData", got.data, exp.data);
                    checkDest("outDest", got.dest, exp.dest);
                    checkLast("outLast", got.last, exp.last);
                end
            end
            if (rowErr[r] != ERR_NONE && !timedOut) begin
                waitForEntry(1'b1);
            end
            while (errQ.size() > 0) begin
                checkErr("errCode", errQ.pop_front(), rowErr[r]);
            end
            $display("test %0d %s: %s", r, rowName[r], errors == errBefore ? "passed" : "FAILED");
        end

        repeat (5) @(posedge clk);
        if (actQ.size() != 0) begin
            $display("%0d output words arrived that no command produced", actQ.size());
            errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", numRows, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
cmdFormatPkg.sv
cmdFlowPkg.sv
cmdWordIf.sv
argHistIf.sv
cmdParser.sv
argHistory.sv
copyOptimizer.sv
cmdInPath.sv
tbCmdInPath.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the command-in path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbCmdInPath -f flist.f -o simv \
    && ./obj_dir/simv > sim.log \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "Everything OK" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
